/* vlog.f */
+incdir+verification
hw/l15_pkg.sv
hw/l1_cache_pkg.sv
hw/adapter_fifo.sv
hw/l15_adapter_ctrl.sv
hw/l15_req_encoder.sv
hw/l15_rtrn_decoder.sv
hw/l15_adapter.sv
verification/l15_adapter_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= l15_adapter_tb
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verification/l15_adapter_ref.svh */
`ifndef L15_ADAPTER_REF_SVH
`define L15_ADAPTER_REF_SVH

////////////////////////////////////////////////////////////
// random source
////////////////////////////////////////////////////////////

logic [31:0] lfsr_q = 32'h44cf_f939;

// fibonacci lfsr, taps 32 22 2 1, one step per bit
function automatic logic [63:0] rand_bits(input int n);
  logic [63:0] r;
  logic fb;
  r = '0;
  for (int i = 0; i < n; i++) begin
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    r = {r[62:0], fb};
  end
  return r;
endfunction

// byte k of the result is byte 7-k of the input
function automatic logic [63:0] reverse_bytes(input logic [63:0] d);
  logic [63:0] r;
  for (int k = 0; k < 8; k++) begin
    for (int b = 0; b < 8; b++) begin
      r[8*k+b] = d[8*(7-k)+b];
    end
  end
  return r;
endfunction

////////////////////////////////////////////////////////////
// expected requests
////////////////////////////////////////////////////////////

function automatic l15_pkg::l15_req_t expect_icache_req(input l1_cache_pkg::icache_req_t r);
  l15_pkg::l15_req_t e;
  e          = '0;
  e.val      = 1'b1;
  e.rqtype   = l15_pkg::L15_IMISS_RQ;
  e.nc       = r.nc;
  e.size     = r.nc ? 3'd2 : 3'd7;  // one word for io, else a line
  e.threadid = r.tid;
  e.l1rplway = r.way;
  e.address  = r.paddr;
  return e;
endfunction

function automatic l15_pkg::l15_req_t expect_dcache_req(input l1_cache_pkg::dcache_req_t r);
  l15_pkg::l15_req_t e;
  e          = '0;
  e.val      = 1'b1;
  e.rqtype   = (r.rtype == l1_cache_pkg::DCACHE_STORE_REQ) ?
               l15_pkg::L15_STORE_RQ : l15_pkg::L15_LOAD_RQ;
  e.nc       = r.nc;
  e.size     = r.size;
  e.threadid = r.tid;
  e.l1rplway = r.way;
  e.address  = r.paddr;
  e.data     = reverse_bytes(r.data);  // big endian on the bus
  return e;
endfunction

// data only matters for stores, req_ack is checked on its own
function automatic bit req_matches(input l15_pkg::l15_req_t e, input l15_pkg::l15_req_t a);
  l15_pkg::l15_req_t c;
  c = a;
  c.req_ack = e.req_ack;
  if (e.rqtype != l15_pkg::L15_STORE_RQ) begin
    c.data = e.data;
  end
  return c == e;
endfunction

////////////////////////////////////////////////////////////
// expected returns
////////////////////////////////////////////////////////////

function automatic void expect_rtrn(input l15_pkg::l15_rtrn_t p,
                                    output bit iv, output l1_cache_pkg::icache_rtrn_t ir,
                                    output bit dv, output l1_cache_pkg::dcache_rtrn_t dr);
  logic [15:0] idx;
  idx = {p.inval_address_15_4, 4'b0000};
  ir.tid  = p.threadid;
  dr.tid  = p.threadid;
  ir.inv  = '{vld: p.inval_icache_inval, all: p.inval_icache_all_way, idx: idx,
              way: p.inval_way};
  dr.inv  = '{vld: p.inval_dcache_inval, all: p.inval_dcache_all_way, idx: idx,
              way: p.inval_way};
  ir.data = {reverse_bytes(p.data_3), reverse_bytes(p.data_2),
             reverse_bytes(p.data_1), reverse_bytes(p.data_0)};
  dr.data = {reverse_bytes(p.data_1), reverse_bytes(p.data_0)};
  ir.rtype = l1_cache_pkg::ICACHE_IFILL_ACK;
  dr.rtype = l1_cache_pkg::DCACHE_LOAD_ACK;
  iv = 1'b0;
  dv = 1'b0;
  case (p.returntype)
    l15_pkg::L15_LOAD_RET:  dv = 1'b1;
    l15_pkg::L15_IFILL_RET: iv = 1'b1;
    l15_pkg::L15_ST_ACK: begin
      dr.rtype = l1_cache_pkg::DCACHE_STORE_ACK;
      dv = 1'b1;
    end
    l15_pkg::L15_EVICT_REQ: begin
      ir.rtype = l1_cache_pkg::ICACHE_INV_REQ;
      dr.rtype = l1_cache_pkg::DCACHE_INV_REQ;
      iv = p.inval_icache_inval | p.inval_icache_all_way;
      dv = p.inval_dcache_inval | p.inval_dcache_all_way;
    end
    default: ;
  endcase
endfunction

`endif

/* verification/l15_adapter_tb.sv */
module l15_adapter_tb;

  localparam int CLK_PERIOD  = 4;
  // reset, imiss and dcache, arbitration, returns and invalidation
  localparam int STIM_CYCLES = 4 + 2 * (6 + 4) + (8 + 12) + 2 * (2 * 9 + 3);

  logic clk_i = 1'b0;
  logic reset_i;
  logic icache_req, icache_ack, icache_rvld;
  logic dcache_req, dcache_ack, dcache_rvld;
  logic l15_ack;
  l1_cache_pkg::icache_req_t  icache_data;
  l1_cache_pkg::dcache_req_t  dcache_data;
  l1_cache_pkg::icache_rtrn_t icache_rtrn;
  l1_cache_pkg::dcache_rtrn_t dcache_rtrn;
  l15_pkg::l15_req_t  l15_req;
  l15_pkg::l15_rtrn_t rtrn_drv, l15_rtrn;

  `include "l15_adapter_ref.svh"

  string cur_test = "reset";
  int errors = 0;
  int checks = 0;
  int test_errors, test_checks;
  int i_acks, d_acks;
  bit arb_check = 1'b0;
  l15_pkg::l15_req_t exp_i[$];
  l15_pkg::l15_req_t exp_d[$];

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  // model l15 ack rides on the return struct
  always_comb begin
    l15_rtrn     = rtrn_drv;
    l15_rtrn.ack = l15_ack;
  end

  l15_adapter i_dut (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .icache_data_req_i(icache_req),
    .icache_data_ack_o(icache_ack),
    .icache_data_i    (icache_data),
    .icache_rtrn_vld_o(icache_rvld),
    .icache_rtrn_o    (icache_rtrn),
    .dcache_data_req_i(dcache_req),
    .dcache_data_ack_o(dcache_ack),
    .dcache_data_i    (dcache_data),
    .dcache_rtrn_vld_o(dcache_rvld),
    .dcache_rtrn_o    (dcache_rtrn),
    .l15_req_o        (l15_req),
    .l15_rtrn_i       (l15_rtrn)
  );

  ////////////////////////////////////////////////////////////
  // comparison
  ////////////////////////////////////////////////////////////

  bit exp_iv, exp_dv, prev_pend, have_last, last_src, src;
  l1_cache_pkg::icache_rtrn_t exp_ir;
  l1_cache_pkg::dcache_rtrn_t exp_dr;
  l15_pkg::l15_req_t prev_req, exp_req, act_req;

  always @(posedge clk_i) begin
    if (reset_i) begin
      exp_iv    = 1'b0;
      exp_dv    = 1'b0;
      prev_pend = 1'b0;
      have_last = 1'b0;
    end else begin
      checks++;
      if (l15_req.req_ack !== l15_rtrn.val) begin  // return FIFO never fills
        $display("CHECK FAILED %s: req_ack expected %b actual %b", cur_test,
                 l15_rtrn.val, l15_req.req_ack);
        errors++;
      end
      // returns accepted one cycle ago
      if (icache_rvld !== exp_iv || (exp_iv && icache_rtrn !== exp_ir)) begin
        $display("CHECK FAILED %s: icache return expected %b/%h actual %b/%h", cur_test,
                 exp_iv, exp_ir, icache_rvld, icache_rtrn);
        errors++;
      end
      if (dcache_rvld !== exp_dv || (exp_dv && dcache_rtrn !== exp_dr)) begin
        $display("CHECK FAILED %s: dcache return expected %b/%h actual %b/%h", cur_test,
                 exp_dv, exp_dr, dcache_rvld, dcache_rtrn);
        errors++;
      end
      exp_iv = 1'b0;
      exp_dv = 1'b0;
      if (l15_req.req_ack) begin
        expect_rtrn(l15_rtrn, exp_iv, exp_ir, exp_dv, exp_dr);
      end
      // held request must not move
      if (prev_pend) begin
        act_req = l15_req;
        act_req.req_ack = prev_req.req_ack;
        if (act_req !== prev_req) begin
          $display("CHECK FAILED %s: held request expected %h actual %h", cur_test,
                   prev_req, act_req);
          errors++;
        end
      end
      prev_pend = l15_req.val && !l15_ack;
      prev_req  = l15_req;
      // accepted request against its source queue
      if (l15_req.val && l15_ack) begin
        src = (l15_req.rqtype != l15_pkg::L15_IMISS_RQ);
        if (arb_check && have_last && exp_i.size() > 0 && exp_d.size() > 0
            && src == last_src) begin
          $display("round robin broken in %s: source %0d won twice in a row", cur_test, src);
          errors++;
        end
        have_last = arb_check;
        last_src  = src;
        if ((src ? exp_d.size() : exp_i.size()) == 0) begin
          $display("unexpected request in %s: %h", cur_test, l15_req);
          errors++;
        end else begin
          exp_req = src ? exp_d.pop_front() : exp_i.pop_front();
          if (!req_matches(exp_req, l15_req)) begin
            $display("CHECK FAILED %s: request expected %h actual %h", cur_test,
                     exp_req, l15_req);
            errors++;
          end
        end
      end
      // requests taken from the caches
      if (icache_req && icache_ack) begin
        exp_i.push_back(expect_icache_req(icache_data));
        i_acks++;
      end
      if (dcache_req && dcache_ack) begin
        exp_d.push_back(expect_dcache_req(dcache_data));
        d_acks++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = errors;
    test_checks = checks;
    i_acks      = 0;
    d_acks      = 0;
  endtask

  task automatic end_test();
    while (exp_i.size() > 0 || exp_d.size() > 0) begin
      @(posedge clk_i);
      #1;
    end
    repeat (2) @(posedge clk_i);  // let the last return come out
    #1;
    $display("test %s: %0d cycles checked, %0d errors", cur_test,
             checks - test_checks, errors - test_errors);
  endtask

  function automatic l1_cache_pkg::icache_req_t random_icache_req();
    l1_cache_pkg::icache_req_t r;
    logic [63:0] rnd;
    rnd = rand_bits(1);
    r.nc = rnd[0];
    rnd = rand_bits(4);
    r.tid = rnd[1:0];
    r.way = rnd[3:2];
    rnd = rand_bits(40);
    r.paddr = rnd[39:0];
    return r;
  endfunction

  function automatic l1_cache_pkg::dcache_req_t random_dcache_req();
    l1_cache_pkg::dcache_req_t r;
    logic [63:0] rnd;
    rnd = rand_bits(8);
    r.rtype = rnd[0] ? l1_cache_pkg::DCACHE_STORE_REQ : l1_cache_pkg::DCACHE_LOAD_REQ;
    r.size  = {1'b0, rnd[2:1]};  // byte up to dword
    r.nc    = rnd[3];
    r.tid   = rnd[5:4];
    r.way   = rnd[7:6];
    rnd = rand_bits(40);
    r.paddr = rnd[39:0];
    r.data  = rand_bits(64);
    return r;
  endfunction

  task automatic send_icache(input l1_cache_pkg::icache_req_t r);
    icache_data = r;
    icache_req  = 1'b1;
    @(posedge clk_i);
    while (!icache_ack) @(posedge clk_i);
    #1 icache_req = 1'b0;
  endtask

  task automatic send_dcache(input l1_cache_pkg::dcache_req_t r);
    dcache_data = r;
    dcache_req  = 1'b1;
    @(posedge clk_i);
    while (!dcache_ack) @(posedge clk_i);
    #1 dcache_req = 1'b0;
  endtask

  // one packet for one cycle, then a random gap
  task automatic send_rtrn(input l15_pkg::l15_rtrn_t p);
    logic [63:0] rnd;
    rtrn_drv     = p;
    rtrn_drv.val = 1'b1;
    @(posedge clk_i);
    #1 rtrn_drv.val = 1'b0;
    rnd = rand_bits(1);
    if (rnd[0]) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  function automatic l15_pkg::l15_rtrn_t random_rtrn();
    l15_pkg::l15_rtrn_t p;
    logic [63:0] rnd;
    p = '0;
    rnd = rand_bits(24);
    p.threadid = rnd[1:0];
    p.inval_way = rnd[3:2];
    p.inval_address_15_4 = rnd[15:4];
    {p.inval_icache_all_way, p.inval_dcache_all_way} = rnd[17:16];
    {p.inval_icache_inval, p.inval_dcache_inval} = rnd[19:18];
    case (rnd[21:20])
      2'd0:    p.returntype = l15_pkg::L15_LOAD_RET;
      2'd1:    p.returntype = l15_pkg::L15_ST_ACK;
      default: p.returntype = l15_pkg::L15_IFILL_RET;
    endcase
    p.data_0 = rand_bits(64);
    p.data_1 = rand_bits(64);
    p.data_2 = rand_bits(64);
    p.data_3 = rand_bits(64);
    return p;
  endfunction

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  initial begin
    #(4 * STIM_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the DUT stopped answering");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    l15_pkg::l15_rtrn_t p;
    reset_i     = 1'b1;
    icache_req  = 1'b0;
    dcache_req  = 1'b0;
    icache_data = '0;
    dcache_data = '0;
    l15_ack     = 1'b0;
    rtrn_drv    = '0;
    repeat (4) @(posedge clk_i);
    #1 reset_i = 1'b0;

    start_test("imiss");
    l15_ack = 1'b1;
    repeat (6) send_icache(random_icache_req());
    end_test();

    start_test("dcache");
    repeat (6) send_dcache(random_dcache_req());
    end_test();

    start_test("arbitration");
    l15_ack   = 1'b0;
    arb_check = 1'b1;
    fork
      begin
        // dcache locks the arbiter alone, icache joins while it is held
        repeat (2) @(posedge clk_i);
        #1;
        repeat (3) send_icache(random_icache_req());
      end
      repeat (3) send_dcache(random_dcache_req());
      begin
        repeat (8) @(posedge clk_i);
        #1;
        if (i_acks != 2 || d_acks != 2 || icache_ack || dcache_ack) begin
          $display("back-pressure in %s: %0d icache and %0d dcache acks, acks now %b%b",
                   cur_test, i_acks, d_acks, icache_ack, dcache_ack);
          errors++;
        end
        l15_ack = 1'b1;
      end
    join
    end_test();
    arb_check = 1'b0;

    start_test("returns");
    repeat (9) send_rtrn(random_rtrn());
    end_test();

    start_test("invalidation");
    repeat (8) begin
      p = random_rtrn();
      p.returntype = l15_pkg::L15_EVICT_REQ;
      send_rtrn(p);
    end
    p = random_rtrn();
    p.returntype = l15_pkg::L15_EVICT_REQ;
    p.inval_icache_all_way = 1'b0;
    p.inval_dcache_all_way = 1'b0;
    p.inval_icache_inval   = 1'b0;
    p.inval_dcache_inval   = 1'b0;
    send_rtrn(p);  // no flags, nothing delivered
    end_test();

    $display("summary: %0d cycles checked, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* hw/l15_adapter.sv */
module l15_adapter (
  input  logic                       clk_i,
  input  logic                       reset_i,
  // icache
  input  logic                       icache_data_req_i,
  output logic                       icache_data_ack_o,
  input  l1_cache_pkg::icache_req_t  icache_data_i,
  output logic                       icache_rtrn_vld_o,  // no back-pressure
  output l1_cache_pkg::icache_rtrn_t icache_rtrn_o,
  // dcache
  input  logic                       dcache_data_req_i,
  output logic                       dcache_data_ack_o,
  input  l1_cache_pkg::dcache_req_t  dcache_data_i,
  output logic                       dcache_rtrn_vld_o,
  output l1_cache_pkg::dcache_rtrn_t dcache_rtrn_o,
  // l15
  output l15_pkg::l15_req_t          l15_req_o,
  input  l15_pkg::l15_rtrn_t         l15_rtrn_i
);

  l1_cache_pkg::icache_req_t icache_head;
  l1_cache_pkg::dcache_req_t dcache_head;
  l15_pkg::l15_rtrn_t        rtrn_head;
  l15_pkg::l15_req_t         enc_req;  // fields without strobes

  logic icache_full, icache_empty, icache_pop;
  logic dcache_full, dcache_empty, dcache_pop;
  logic rtrn_full, rtrn_empty, rtrn_pop;
  logic arb_idx, l15_val, l15_req_ack;

  ////////////////////////////////////////////////////////////
  // queues
  ////////////////////////////////////////////////////////////

  adapter_fifo #(
    .WIDTH($bits(l1_cache_pkg::icache_req_t)),
    .DEPTH(l1_cache_pkg::REQ_FIFO_DEPTH)
  ) i_icache_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .push_i (icache_data_ack_o),
    .data_i (icache_data_i),
    .pop_i  (icache_pop),
    .data_o (icache_head),
    .full_o (icache_full),
    .empty_o(icache_empty)
  );

  adapter_fifo #(
    .WIDTH($bits(l1_cache_pkg::dcache_req_t)),
    .DEPTH(l1_cache_pkg::REQ_FIFO_DEPTH)
  ) i_dcache_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .push_i (dcache_data_ack_o),
    .data_i (dcache_data_i),
    .pop_i  (dcache_pop),
    .data_o (dcache_head),
    .full_o (dcache_full),
    .empty_o(dcache_empty)
  );

  adapter_fifo #(
    .WIDTH($bits(l15_pkg::l15_rtrn_t)),
    .DEPTH(l1_cache_pkg::RTRN_FIFO_DEPTH)
  ) i_rtrn_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .push_i (l15_req_ack),  // accepted packet
    .data_i (l15_rtrn_i),
    .pop_i  (rtrn_pop),
    .data_o (rtrn_head),
    .full_o (rtrn_full),
    .empty_o(rtrn_empty)
  );

  ////////////////////////////////////////////////////////////
  // control, encode, decode
  ////////////////////////////////////////////////////////////

  l15_adapter_ctrl i_ctrl (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .icache_req_i  (icache_data_req_i),
    .dcache_req_i  (dcache_data_req_i),
    .icache_full_i (icache_full),
    .icache_empty_i(icache_empty),
    .dcache_full_i (dcache_full),
    .dcache_empty_i(dcache_empty),
    .l15_ack_i     (l15_rtrn_i.ack),
    .l15_rtrn_val_i(l15_rtrn_i.val),
    .rtrn_full_i   (rtrn_full),
    .rtrn_empty_i  (rtrn_empty),
    .icache_ack_o  (icache_data_ack_o),
    .dcache_ack_o  (dcache_data_ack_o),
    .icache_pop_o  (icache_pop),
    .dcache_pop_o  (dcache_pop),
    .arb_idx_o     (arb_idx),
    .l15_val_o     (l15_val),
    .l15_req_ack_o (l15_req_ack),
    .rtrn_pop_o    (rtrn_pop)
  );

  l15_req_encoder i_req_encoder (
    .arb_idx_i    (arb_idx),
    .icache_head_i(icache_head),
    .dcache_head_i(dcache_head),
    .l15_req_o    (enc_req)
  );

  // strobes from the controller
  always_comb begin
    l15_req_o         = enc_req;
    l15_req_o.val     = l15_val;
    l15_req_o.req_ack = l15_req_ack;
  end

  l15_rtrn_decoder i_rtrn_decoder (
    .rtrn_vld_i       (rtrn_pop),
    .rtrn_i           (rtrn_head),
    .icache_rtrn_vld_o(icache_rtrn_vld_o),
    .icache_rtrn_o    (icache_rtrn_o),
    .dcache_rtrn_vld_o(dcache_rtrn_vld_o),
    .dcache_rtrn_o    (dcache_rtrn_o)
  );

endmodule

/* hw/l15_rtrn_decoder.sv */
module l15_rtrn_decoder (
  input  logic                       rtrn_vld_i,  // FIFO head popped this cycle
  input  l15_pkg::l15_rtrn_t         rtrn_i,
  output logic                       icache_rtrn_vld_o,
  output l1_cache_pkg::icache_rtrn_t icache_rtrn_o,
  output logic                       dcache_rtrn_vld_o,
  output l1_cache_pkg::dcache_rtrn_t dcache_rtrn_o
);

  l1_cache_pkg::cache_idx_t   inv_idx;
  l1_cache_pkg::cache_inval_t icache_inv, dcache_inv;
  l1_cache_pkg::icache_line_t icache_line;
  l1_cache_pkg::dcache_line_t dcache_line;

  ////////////////////////////////////////////////////////////
  // data and invalidation mapping
  ////////////////////////////////////////////////////////////

  // word 0 is the low part, every word back to little endian
  assign icache_line = {
    l15_pkg::swap_bytes64(rtrn_i.data_3),
    l15_pkg::swap_bytes64(rtrn_i.data_2),
    l15_pkg::swap_bytes64(rtrn_i.data_1),
    l15_pkg::swap_bytes64(rtrn_i.data_0)
  };
  assign dcache_line = {
    l15_pkg::swap_bytes64(rtrn_i.data_1),
    l15_pkg::swap_bytes64(rtrn_i.data_0)
  };

  assign inv_idx = {rtrn_i.inval_address_15_4, 4'b0000};  // line aligned

  assign icache_inv = '{
    vld: rtrn_i.inval_icache_inval,
    all: rtrn_i.inval_icache_all_way,
    idx: inv_idx,
    way: rtrn_i.inval_way
  };
  assign dcache_inv = '{
    vld: rtrn_i.inval_dcache_inval,
    all: rtrn_i.inval_dcache_all_way,
    idx: inv_idx,
    way: rtrn_i.inval_way
  };

  ////////////////////////////////////////////////////////////
  // type decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    icache_rtrn_o = '{rtype: l1_cache_pkg::ICACHE_IFILL_ACK, tid: rtrn_i.threadid,
                      inv: icache_inv, data: icache_line};
    dcache_rtrn_o = '{rtype: l1_cache_pkg::DCACHE_LOAD_ACK, tid: rtrn_i.threadid,
                      inv: dcache_inv, data: dcache_line};
    icache_rtrn_vld_o = 1'b0;
    dcache_rtrn_vld_o = 1'b0;

    if (rtrn_vld_i) begin
      unique case (rtrn_i.returntype)
        l15_pkg::L15_LOAD_RET: dcache_rtrn_vld_o = 1'b1;
        l15_pkg::L15_ST_ACK: begin
          dcache_rtrn_o.rtype = l1_cache_pkg::DCACHE_STORE_ACK;
          dcache_rtrn_vld_o   = 1'b1;
        end
        l15_pkg::L15_IFILL_RET: icache_rtrn_vld_o = 1'b1;
        l15_pkg::L15_EVICT_REQ: begin
          icache_rtrn_o.rtype = l1_cache_pkg::ICACHE_INV_REQ;
          dcache_rtrn_o.rtype = l1_cache_pkg::DCACHE_INV_REQ;
          icache_rtrn_vld_o   = icache_inv.vld | icache_inv.all;  // only if flagged
          dcache_rtrn_vld_o   = dcache_inv.vld | dcache_inv.all;
        end
        default: ;  // unknown type, dropped
      endcase
    end
  end

endmodule

/* hw/l15_req_encoder.sv */
module l15_req_encoder (
  input  logic                      arb_idx_i,      // 0: icache, 1: dcache
  input  l1_cache_pkg::icache_req_t icache_head_i,
  input  l1_cache_pkg::dcache_req_t dcache_head_i,
  output l15_pkg::l15_req_t         l15_req_o
);

  l15_pkg::l15_size_t icache_size;

  // io space fills are one 4-byte word
  assign icache_size = icache_head_i.nc ? l15_pkg::L15_SIZE_WORD : l15_pkg::L15_SIZE_LINE;

  always_comb begin
    l15_req_o = '0;  // val and req_ack filled in at the top

    // store word to big endian, don't care for other types
    l15_req_o.data = l15_pkg::swap_bytes64(dcache_head_i.data);

    if (arb_idx_i) begin
      l15_req_o.nc       = dcache_head_i.nc;
      l15_req_o.size     = dcache_head_i.size;  // as given by the dcache
      l15_req_o.threadid = dcache_head_i.tid;
      l15_req_o.l1rplway = dcache_head_i.way;
      l15_req_o.address  = dcache_head_i.paddr;
      unique case (dcache_head_i.rtype)
        l1_cache_pkg::DCACHE_STORE_REQ: begin
          l15_req_o.rqtype = l15_pkg::L15_STORE_RQ;
        end
        default: begin
          l15_req_o.rqtype = l15_pkg::L15_LOAD_RQ;
        end
      endcase
    end else begin
      l15_req_o.nc       = icache_head_i.nc;
      l15_req_o.size     = icache_size;
      l15_req_o.threadid = icache_head_i.tid;
      l15_req_o.l1rplway = icache_head_i.way;
      l15_req_o.address  = icache_head_i.paddr;
      l15_req_o.rqtype   = l15_pkg::L15_IMISS_RQ;  // icache only misses
    end
  end

endmodule

/* hw/l15_adapter_ctrl.sv */
module l15_adapter_ctrl (
  input  logic clk_i,
  input  logic reset_i,
  // cache request side
  input  logic icache_req_i,
  input  logic dcache_req_i,
  input  logic icache_full_i,
  input  logic icache_empty_i,
  input  logic dcache_full_i,
  input  logic dcache_empty_i,
  // l15 handshake
  input  logic l15_ack_i,
  input  logic l15_rtrn_val_i,
  input  logic rtrn_full_i,
  input  logic rtrn_empty_i,
  output logic icache_ack_o,    // also the icache FIFO push
  output logic dcache_ack_o,    // also the dcache FIFO push
  output logic icache_pop_o,
  output logic dcache_pop_o,
  output logic arb_idx_o,       // 0: icache, 1: dcache
  output logic l15_val_o,
  output logic l15_req_ack_o,
  output logic rtrn_pop_o
);

  typedef enum logic {
    ARB_IDLE,
    ARB_LOCKED  // request out, waiting for l15 ack
  } arb_state_e;

  arb_state_e state_q;
  logic last_q;  // last winner, 1 = dcache
  logic idx_q;   // winner held while locked
  logic choice;
  logic icache_pend, dcache_pend;
  logic xfer;

  ////////////////////////////////////////////////////////////
  // request path
  ////////////////////////////////////////////////////////////

  assign icache_ack_o = icache_req_i & ~icache_full_i;
  assign dcache_ack_o = dcache_req_i & ~dcache_full_i;

  assign icache_pend = ~icache_empty_i;
  assign dcache_pend = ~dcache_empty_i;
  assign l15_val_o   = icache_pend | dcache_pend;

  // round robin, prefer the one that lost last time
  always_comb begin
    if (icache_pend && dcache_pend) begin
      choice = ~last_q;
    end else begin
      choice = dcache_pend;  // single requester wins
    end
  end

  assign arb_idx_o    = (state_q == ARB_LOCKED) ? idx_q : choice;
  assign xfer         = l15_val_o & l15_ack_i;
  assign icache_pop_o = xfer & ~arb_idx_o;
  assign dcache_pop_o = xfer & arb_idx_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ARB_IDLE;
      idx_q   <= 1'b0;
      last_q  <= 1'b1;  // so icache goes first
    end else begin
      unique case (state_q)
        ARB_IDLE: begin
          if (l15_val_o && l15_ack_i) begin
            last_q <= choice;  // taken in the same cycle
          end else if (l15_val_o) begin
            state_q <= ARB_LOCKED;
            idx_q   <= choice;
          end
        end
        ARB_LOCKED: begin
          if (l15_ack_i) begin
            state_q <= ARB_IDLE;
            last_q  <= idx_q;
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // return path
  ////////////////////////////////////////////////////////////

  assign l15_req_ack_o = l15_rtrn_val_i & ~rtrn_full_i;  // room for it
  assign rtrn_pop_o    = ~rtrn_empty_i;  // caches take it unconditionally

endmodule

/* hw/adapter_fifo.sv */
module adapter_fifo #(
  parameter int unsigned WIDTH = 8,
  parameter int unsigned DEPTH = 2
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,  // head, valid when not empty
  output logic             full_o,
  output logic             empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

  logic [WIDTH-1:0] mem_q [DEPTH];  // storage
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic push_en, pop_en;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];  // no bypass

  // guard against overflow and underflow
  assign push_en = push_i & ~full_o;
  assign pop_en  = pop_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;  // wrap
      end
      if (pop_en) begin
        rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_en && !pop_en) begin
        count_q <= count_q + 1'b1;
      end else if (pop_en && !push_en) begin
        count_q <= count_q - 1'b1;
      end  // both or neither: count holds
    end
  end

  // payload, no reset
  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

/* hw/l1_cache_pkg.sv */
package l1_cache_pkg;

  ////////////////////////////////////////////////////////////
  // adapter queue sizing
  ////////////////////////////////////////////////////////////

  localparam int unsigned REQ_FIFO_DEPTH  = 2;  // per cache
  localparam int unsigned RTRN_FIFO_DEPTH = 2;

  localparam int unsigned CACHE_IDX_WIDTH   = 16;
  localparam int unsigned ICACHE_LINE_WIDTH = 256;  // four bus words
  localparam int unsigned DCACHE_LINE_WIDTH = 128;  // two bus words

  typedef logic [CACHE_IDX_WIDTH-1:0]   cache_idx_t;
  typedef logic [ICACHE_LINE_WIDTH-1:0] icache_line_t;
  typedef logic [DCACHE_LINE_WIDTH-1:0] dcache_line_t;

  ////////////////////////////////////////////////////////////
  // request and return kinds
  ////////////////////////////////////////////////////////////

  typedef enum logic {
    DCACHE_LOAD_REQ  = 1'b0,
    DCACHE_STORE_REQ = 1'b1
  } dcache_rtype_e;

  typedef enum logic {
    ICACHE_IFILL_ACK = 1'b0,
    ICACHE_INV_REQ   = 1'b1
  } icache_rtrn_e;

  typedef enum logic [1:0] {
    DCACHE_LOAD_ACK  = 2'd0,
    DCACHE_STORE_ACK = 2'd1,
    DCACHE_INV_REQ   = 2'd2
  } dcache_rtrn_e;

  typedef struct packed {
    logic               nc;
    l15_pkg::l15_tid_t  tid;
    l15_pkg::l15_way_t  way;    // fill way
    l15_pkg::l15_addr_t paddr;
  } icache_req_t;

  typedef struct packed {
    dcache_rtype_e      rtype;
    l15_pkg::l15_size_t size;
    logic               nc;
    l15_pkg::l15_tid_t  tid;
    l15_pkg::l15_way_t  way;
    l15_pkg::l15_addr_t paddr;
    l15_pkg::l15_data_t data;   // little endian
  } dcache_req_t;

  typedef struct packed {
    logic              vld;  // one line, one way
    logic              all;  // whole set, every way
    cache_idx_t        idx;
    l15_pkg::l15_way_t way;
  } cache_inval_t;

  typedef struct packed {
    icache_rtrn_e      rtype;
    l15_pkg::l15_tid_t tid;
    cache_inval_t      inv;
    icache_line_t      data;
  } icache_rtrn_t;

  typedef struct packed {
    dcache_rtrn_e      rtype;
    l15_pkg::l15_tid_t tid;
    cache_inval_t      inv;
    dcache_line_t      data;
  } dcache_rtrn_t;

endpackage

/* hw/l15_pkg.sv */
package l15_pkg;

  ////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned L15_ADDR_WIDTH = 40;  // physical address
  localparam int unsigned L15_DATA_WIDTH = 64;  // one bus word
  localparam int unsigned L15_TID_WIDTH  = 2;   // thread id doubles as tag
  localparam int unsigned L15_WAY_WIDTH  = 2;

  typedef logic [L15_ADDR_WIDTH-1:0] l15_addr_t;
  typedef logic [L15_DATA_WIDTH-1:0] l15_data_t;  // big endian on this side
  typedef logic [L15_TID_WIDTH-1:0]  l15_tid_t;
  typedef logic [L15_WAY_WIDTH-1:0]  l15_way_t;
  typedef logic [2:0]                l15_size_t;
  typedef logic [15:4]               l15_inval_idx_t;  // line address bits only

  // transaction size codes
  localparam l15_size_t L15_SIZE_BYTE  = 3'd0;
  localparam l15_size_t L15_SIZE_HALF  = 3'd1;
  localparam l15_size_t L15_SIZE_WORD  = 3'd2;
  localparam l15_size_t L15_SIZE_DWORD = 3'd3;
  localparam l15_size_t L15_SIZE_LINE  = 3'd7;  // full cache line

  ////////////////////////////////////////////////////////////
  // packet types
  ////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    L15_LOAD_RQ  = 5'd0,
    L15_STORE_RQ = 5'd1,
    L15_IMISS_RQ = 5'd16  // instruction fill
  } l15_rqtype_e;

  typedef enum logic [3:0] {
    L15_LOAD_RET  = 4'd0,
    L15_IFILL_RET = 4'd1,
    L15_EVICT_REQ = 4'd3,  // invalidation from below
    L15_ST_ACK    = 4'd4
  } l15_rtrntype_e;

  typedef struct packed {
    logic          val;       // request valid
    logic          req_ack;   // accepts the current return packet
    l15_rqtype_e   rqtype;
    logic          nc;        // non-cacheable
    l15_size_t     size;
    l15_tid_t      threadid;
    l15_way_t      l1rplway;  // way to replace
    l15_addr_t     address;
    l15_data_t     data;      // store word
  } l15_req_t;

  typedef struct packed {
    logic           ack;  // request taken
    logic           val;  // return packet valid
    l15_rtrntype_e  returntype;
    logic           noncacheable;
    l15_tid_t       threadid;
    l15_data_t      data_0;
    l15_data_t      data_1;
    l15_data_t      data_2;  // upper half only for ifill
    l15_data_t      data_3;
    logic           inval_icache_all_way;
    logic           inval_dcache_all_way;
    logic           inval_icache_inval;
    logic           inval_dcache_inval;
    l15_inval_idx_t inval_address_15_4;
    l15_way_t       inval_way;
  } l15_rtrn_t;

  // reverse byte order of one bus word, works in both directions
  function automatic l15_data_t swap_bytes64(input l15_data_t d);
    l15_data_t r;
    for (int i = 0; i < 8; i++) begin
      r[8*i +: 8] = d[8*(7-i) +: 8];
    end
    return r;
  endfunction

endpackage
